// File: logic/rf_pkg.sv
// Shared widths, packed request and response structs and APB register offsets
// for the power-gated register file subsystem
package rf_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------

    // Storage array address and payload widths
    localparam int ADDR_W = 3;
    localparam int DATA_W = 19;

    // APB address and data widths
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Wake delay field and drop counter widths
    localparam int WAKE_W = 4;
    localparam int DROP_W = 16;

    typedef logic [ADDR_W-1:0] rf_addr_t;
    typedef logic [DATA_W-1:0] rf_data_t;

    // ------------------------------------------------------------
    // Array ports
    // ------------------------------------------------------------

    // One write request, 23 bits in total
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    // One read request, 4 bits in total
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
    } rf_rd_req_t;

    // ------------------------------------------------------------
    // APB and power control
    // ------------------------------------------------------------

    // Requester side of the APB bus
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    // Completer side of the APB bus
    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Power request and wake delay, register block to sequencer
    typedef struct packed {
        logic              req;
        logic [WAKE_W-1:0] wake;
    } pwr_cfg_t;

    // Sequencer state as seen by software
    typedef struct packed {
        logic powered;
        logic isolated;
        logic busy;
    } pwr_status_t;

    // Register offsets on the APB bus
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] REG_WAKE   = 8'h04;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;
    localparam logic [APB_AW-1:0] REG_DROP   = 8'h0C;

endpackage

// File: logic/rf_array.sv
// Two-port storage array with a registered read port, request blocking
// while isolated and full clearing while the power enable is off
`timescale 1ns/100ps

module rf_array import rf_pkg::*; #(
    parameter int DEPTH = 8
) (
     input  logic       clk
    ,input  logic       reset
    ,input  rf_wr_req_t wr
    ,input  rf_rd_req_t rd
    ,input  logic       isolate
    ,input  logic       pwr_enable_b
    ,output rf_data_t   rdata
    ,output logic       dropped
);

    // Storage entries, no reset since power loss clears them
    rf_data_t mem [DEPTH];

    // Registered read data, held until the next accepted read
    rf_data_t rdata_q;

    logic wr_accept;
    logic rd_accept;
    logic wr_in_range;
    logic rd_in_range;

    // ------------------------------------------------------------
    // Request qualification
    // ------------------------------------------------------------

    // Requests only reach the array while isolation is released
    assign wr_accept = wr.en && !isolate;
    assign rd_accept = rd.en && !isolate;

    // Entries at DEPTH and above do not exist
    assign wr_in_range = int'(wr.addr) < DEPTH;
    assign rd_in_range = int'(rd.addr) < DEPTH;

    // One pulse per cycle even when both ports hit an isolated array
    assign dropped = isolate && (wr.en || rd.en);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // With the enable off every entry is forced to zero, which is
    // how the loss of contents shows up after the next power-up
    always_ff @(posedge clk) begin
        if (pwr_enable_b) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_accept && wr_in_range) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read samples the entry before any same-cycle write lands,
    // so a read and write to one address return the old data
    always_ff @(posedge clk) begin
        if (reset || pwr_enable_b) begin
            rdata_q <= '0;
        end else if (rd_accept) begin
            rdata_q <= rd_in_range ? mem[rd.addr] : '0;
        end
    end

    // Output clamp while isolated
    assign rdata = isolate ? '0 : rdata_q;

endmodule

// File: logic/rf_power_seq.sv
// Power sequencer FSM that orders the array power enable, the wake delay
// and the isolation control, and reports powered, isolated and busy
`timescale 1ns/100ps

module rf_power_seq import rf_pkg::*; (
     input  logic        clk
    ,input  logic        reset
    ,input  pwr_cfg_t    pwr_cfg
    ,output logic        isolate
    ,output logic        pwr_enable_b
    ,output pwr_status_t pwr_status
);

    // Off, enabled but waiting, fully on, isolated but still enabled
    typedef enum logic [1:0] {
        ST_OFF       = 2'd0,
        ST_WAKING    = 2'd1,
        ST_ON        = 2'd2,
        ST_ISOLATING = 2'd3
    } seq_state_t;

    seq_state_t        state_q;
    logic [WAKE_W-1:0] wake_cnt_q;

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------

    // Isolation and power enable are registered so that the array
    // sees clean edges on both controls
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= ST_OFF;
            wake_cnt_q   <= '0;
            isolate      <= 1'b1;
            pwr_enable_b <= 1'b1;
        end else begin
            case (state_q)
                // Enable the array first and load the wake counter
                ST_OFF: begin
                    if (pwr_cfg.req) begin
                        state_q      <= ST_WAKING;
                        wake_cnt_q   <= pwr_cfg.wake;
                        pwr_enable_b <= 1'b0;
                    end
                end

                // Count down the wake delay, then release isolation
                // The request is not looked at until this completes
                ST_WAKING: begin
                    if (wake_cnt_q == '0) begin
                        state_q <= ST_ON;
                        isolate <= 1'b0;
                    end else begin
                        wake_cnt_q <= wake_cnt_q - 1'b1;
                    end
                end

                // Isolate before removing power
                ST_ON: begin
                    if (!pwr_cfg.req) begin
                        state_q <= ST_ISOLATING;
                        isolate <= 1'b1;
                    end
                end

                // Isolation has been up for one cycle, drop the enable
                ST_ISOLATING: begin
                    state_q      <= ST_OFF;
                    pwr_enable_b <= 1'b1;
                end

                default: begin
                    state_q      <= ST_OFF;
                    isolate      <= 1'b1;
                    pwr_enable_b <= 1'b1;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Status
    // ------------------------------------------------------------

    // Powered covers the isolating cycle as the enable is still on there
    assign pwr_status.powered  = (state_q == ST_ON) || (state_q == ST_ISOLATING);
    assign pwr_status.isolated = isolate;

    // Busy marks the two transitional states
    assign pwr_status.busy     = (state_q == ST_WAKING) || (state_q == ST_ISOLATING);

endmodule

// File: logic/rf_apb_regs.sv
// APB slave with the power control, wake delay, status and drop count
// registers, and the power configuration sent to the sequencer
`timescale 1ns/100ps

module rf_apb_regs import rf_pkg::*; #(
    parameter int unsigned RESET_WAKE = 4
) (
     input  logic        clk
    ,input  logic        reset
    ,input  apb_req_t    apb_req
    ,output apb_rsp_t    apb_rsp
    ,input  pwr_status_t pwr_status
    ,input  logic        dropped
    ,output pwr_cfg_t    pwr_cfg
);

    // Register storage
    logic              ctrl_req_q;
    logic [WAKE_W-1:0] wake_q;
    logic [DROP_W-1:0] drop_cnt_q;

    // Transfer decode
    logic access;
    logic wr_access;
    logic rd_access;
    logic hit_ctrl;
    logic hit_wake;
    logic hit_status;
    logic hit_drop;
    logic mapped;

    logic [APB_DW-1:0] rd_mux;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    // Only the access cycle does anything, since pready is always high
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    assign hit_ctrl   = apb_req.paddr == REG_CTRL;
    assign hit_wake   = apb_req.paddr == REG_WAKE;
    assign hit_status = apb_req.paddr == REG_STATUS;
    assign hit_drop   = apb_req.paddr == REG_DROP;

    assign mapped = hit_ctrl || hit_wake || hit_status || hit_drop;

    // ------------------------------------------------------------
    // Control and wake registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_req_q <= 1'b0;
            wake_q     <= WAKE_W'(RESET_WAKE);
        end else if (wr_access) begin
            if (hit_ctrl) begin
                ctrl_req_q <= apb_req.pwdata[0];
            end
            if (hit_wake) begin
                wake_q <= apb_req.pwdata[WAKE_W-1:0];
            end
        end
    end

    // The sequencer samples the raw request level
    assign pwr_cfg.req  = ctrl_req_q;
    assign pwr_cfg.wake = wake_q;

    // ------------------------------------------------------------
    // Drop counter
    // ------------------------------------------------------------

    // A clearing write wins over a drop in the same cycle
    // Count stops at all ones instead of wrapping
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_cnt_q <= '0;
        end else if (wr_access && hit_drop) begin
            drop_cnt_q <= '0;
        end else if (dropped && (drop_cnt_q != '1)) begin
            drop_cnt_q <= drop_cnt_q + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Read data and response
    // ------------------------------------------------------------

    // Unmapped offsets fall through to zero
    always_comb begin
        rd_mux = '0;
        if (hit_ctrl) begin
            rd_mux[0] = ctrl_req_q;
        end
        if (hit_wake) begin
            rd_mux[WAKE_W-1:0] = wake_q;
        end
        if (hit_status) begin
            rd_mux[2:0] = pwr_status;
        end
        if (hit_drop) begin
            rd_mux[DROP_W-1:0] = drop_cnt_q;
        end
    end

    // Read data is only presented in a read access cycle
    assign apb_rsp.prdata  = rd_access ? rd_mux : '0;

    // No wait states on this bus
    assign apb_rsp.pready  = 1'b1;

    // Error on any access to an offset that is not decoded
    assign apb_rsp.pslverr = access && !mapped;

endmodule

// File: logic/rf_mem_top.sv
// Top level of the power-gated register file: APB registers, power
// sequencer and storage array, with the depth and wake reset value set here
`timescale 1ns/100ps

module rf_mem_top import rf_pkg::*; #(
    parameter int          DEPTH      = 8,
    parameter int unsigned RESET_WAKE = 4
) (
     input  logic       clk
    ,input  logic       reset

    // Configuration bus
    ,input  apb_req_t   apb_req
    ,output apb_rsp_t   apb_rsp

    // Array ports
    ,input  rf_wr_req_t wr
    ,input  rf_rd_req_t rd
    ,output rf_data_t   rdata

    // Array power enable, active low
    ,output logic       pwr_enable_b
);

    // ------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------

    pwr_cfg_t    pwr_cfg;
    pwr_status_t pwr_status;
    logic        isolate;
    logic        dropped;

    // Software view of the power state and the drop count
    rf_apb_regs #(
        .RESET_WAKE (RESET_WAKE)
    ) u_regs (
         .clk        (clk)
        ,.reset      (reset)
        ,.apb_req    (apb_req)
        ,.apb_rsp    (apb_rsp)
        ,.pwr_status (pwr_status)
        ,.dropped    (dropped)
        ,.pwr_cfg    (pwr_cfg)
    );

    // Enable and isolation ordering for the array
    rf_power_seq u_seq (
         .clk          (clk)
        ,.reset        (reset)
        ,.pwr_cfg      (pwr_cfg)
        ,.isolate      (isolate)
        ,.pwr_enable_b (pwr_enable_b)
        ,.pwr_status   (pwr_status)
    );

    // Storage, shares the enable that leaves the top level
    rf_array #(
        .DEPTH (DEPTH)
    ) u_array (
         .clk          (clk)
        ,.reset        (reset)
        ,.wr           (wr)
        ,.rd           (rd)
        ,.isolate      (isolate)
        ,.pwr_enable_b (pwr_enable_b)
        ,.rdata        (rdata)
        ,.dropped      (dropped)
    );

endmodule

// File: tests/tb_clock_gen.sv
// Testbench clock and reset generator
// Free running clock and a reset held for a fixed number of rising edges
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
     output logic clk
    ,output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released a little after the edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: tests/rf_tb.sv
// Testbench for the power-gated register file: APB and array driver tasks,
// reference model of the array, power state and drop count, compare tasks,
// watchdog and the closing report
`timescale 1ns/100ps

module rf_tb import rf_pkg::*; ();

    localparam int          DEPTH          = 8;
    localparam int unsigned RESET_WAKE     = 4;
    localparam int          CLK_PERIOD     = 10;
    localparam int          DRIVE_DLY      = 1;
    localparam int          SEED           = 62970;
    localparam int          TRAFFIC_CYCLES = 300;
    localparam int          DROP_CYCLES    = 60;
    localparam int          POLL_LIMIT     = 40;
    // Traffic and drop cycles, array accesses, status polls and other APB transfers
    localparam int TOTAL_OPS  = TRAFFIC_CYCLES + DROP_CYCLES + 4 * DEPTH + 3 * POLL_LIMIT + 60;
    localparam int TIMEOUT_NS = TOTAL_OPS * 20 * CLK_PERIOD + 2000;

    // STATUS reads as {powered, isolated, busy}
    localparam logic [APB_DW-1:0] STATUS_OFF = 32'h2;
    localparam logic [APB_DW-1:0] STATUS_ON  = 32'h4;

    logic       clk;
    logic       reset;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    rf_wr_req_t wr;
    rf_rd_req_t rd;
    rf_data_t   rdata;
    logic       pwr_enable_b;

    // Reference model
    rf_data_t          mem_model [DEPTH];
    rf_data_t          exp_rdata;
    logic              model_powered;
    logic [DROP_W-1:0] model_drops;
    logic [WAKE_W-1:0] model_wake;

    int pass_count;
    int fail_count;
    int fails_before;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD)
       ,.RESET_CYCLES (4)
    ) u_clk_gen (
         .clk   (clk)
        ,.reset (reset)
    );

    rf_mem_top #(
        .DEPTH      (DEPTH)
       ,.RESET_WAKE (RESET_WAKE)
    ) u_dut (
         .clk          (clk)
        ,.reset        (reset)
        ,.apb_req      (apb_req)
        ,.apb_rsp      (apb_rsp)
        ,.wr           (wr)
        ,.rd           (rd)
        ,.rdata        (rdata)
        ,.pwr_enable_b (pwr_enable_b)
    );

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_data(input string name, input rf_data_t got, input rf_data_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // The access cycle carries read data, ready and error together
    task automatic check_apb(input string name, input apb_rsp_t got, input apb_rsp_t exp);
        if (got.prdata !== exp.prdata || got.pready !== exp.pready
                || got.pslverr !== exp.pslverr) begin
            $display("ERR t=%0t %s: got prdata/pready/pslverr %h/%b/%b, expected %h/%b/%b",
                     $time, name, got.prdata, got.pready, got.pslverr,
                     exp.prdata, exp.pready, exp.pslverr);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %b, expected %b", $time, name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("FAIL t=%0t: %s", $time, what);
        fail_count++;
    endtask

    function automatic apb_rsp_t expected_rsp(input logic [APB_DW-1:0] data, input logic err);
        apb_rsp_t r;
        r.prdata  = data;
        r.pready  = 1'b1;
        r.pslverr = err;
        return r;
    endfunction

    // Entries past DEPTH do not exist and read as zero
    function automatic rf_data_t model_entry(input rf_addr_t addr);
        return (int'(addr) < DEPTH) ? mem_model[addr] : '0;
    endfunction

    // ------------------------------------------------------------
    // Bus and array drivers
    // ------------------------------------------------------------

    // Setup cycle, then access cycle sampled at the falling edge, then idle
    task automatic apb_transfer(input logic wr_en, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] data, output apb_rsp_t rsp);
        @(posedge clk);
        #(DRIVE_DLY);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr_en;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #(DRIVE_DLY);
        apb_req.penable = 1'b1;
        @(negedge clk);
        rsp = apb_rsp;
        @(posedge clk);
        #(DRIVE_DLY);
        apb_req = '0;
    endtask

    task automatic read_and_compare(input string name, input logic [APB_AW-1:0] addr,
                                    input logic [APB_DW-1:0] data, input logic err);
        apb_rsp_t rsp;
        apb_transfer(1'b0, addr, '0, rsp);
        check_apb(name, rsp, expected_rsp(data, err));
    endtask

    task automatic write_and_compare(input string name, input logic [APB_AW-1:0] addr,
                                     input logic [APB_DW-1:0] data, input logic err);
        apb_rsp_t rsp;
        apb_transfer(1'b1, addr, data, rsp);
        check_bit(name, rsp.pslverr, err);
    endtask

    task automatic array_write(input rf_addr_t addr, input rf_data_t data);
        @(posedge clk);
        #(DRIVE_DLY);
        wr = '{en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #(DRIVE_DLY);
        wr = '0;
    endtask

    task automatic array_read(input rf_addr_t addr, output rf_data_t data);
        @(posedge clk);
        #(DRIVE_DLY);
        rd = '{en: 1'b1, addr: addr};
        @(posedge clk);
        #(DRIVE_DLY);
        rd   = '0;
        data = rdata;
    endtask

    // ------------------------------------------------------------
    // Power control and random traffic
    // ------------------------------------------------------------

    task automatic power_up(input logic [WAKE_W-1:0] wake);
        apb_rsp_t rsp;
        int       polls;
        model_wake = wake;
        write_and_compare("WAKE write pslverr", REG_WAKE, 32'(wake), 1'b0);
        read_and_compare("WAKE", REG_WAKE, 32'(wake), 1'b0);
        write_and_compare("CTRL write pslverr", REG_CTRL, 32'h1, 1'b0);
        // The request lands at the end of the access cycle, the enable one cycle later
        check_bit("pwr_enable_b", pwr_enable_b, 1'b1);
        @(posedge clk);
        #(DRIVE_DLY);
        check_bit("pwr_enable_b", pwr_enable_b, 1'b0);
        polls = 0;
        rsp   = '0;
        while (!rsp.prdata[2] && polls < POLL_LIMIT) begin
            apb_transfer(1'b0, REG_STATUS, '0, rsp);
            polls++;
        end
        if (!rsp.prdata[2]) begin
            report_failure("STATUS never showed powered after the power request rose");
        end else begin
            check_apb("STATUS", rsp, expected_rsp(STATUS_ON, 1'b0));
        end
        model_powered = 1'b1;
        exp_rdata     = '0;
    endtask

    // Contents are lost, so the model clears with the power
    task automatic power_down();
        int waits;
        write_and_compare("CTRL write pslverr", REG_CTRL, 32'h0, 1'b0);
        waits = 0;
        while (!pwr_enable_b && waits < 8) begin
            @(posedge clk);
            #(DRIVE_DLY);
            waits++;
        end
        if (!pwr_enable_b) begin
            report_failure("pwr_enable_b stayed low after the power request fell");
        end
        read_and_compare("STATUS", REG_STATUS, STATUS_OFF, 1'b0);
        model_powered = 1'b0;
        exp_rdata     = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mem_model[i] = '0;
        end
    endtask

    // Checks the result of the previous cycle, then drives a new random request
    task automatic random_cycle();
        rf_wr_req_t w;
        rf_rd_req_t r;
        @(posedge clk);
        #(DRIVE_DLY);
        check_data("rdata", rdata, exp_rdata);
        w.en   = 1'($urandom_range(1));
        w.addr = rf_addr_t'($urandom);
        w.data = rf_data_t'($urandom);
        r.en   = 1'($urandom_range(1));
        // A quarter of the reads hit the address being written
        r.addr = ($urandom_range(3) == 0) ? w.addr : rf_addr_t'($urandom);
        wr = w;
        rd = r;
        if (!model_powered) begin
            // Both ports dropped in one cycle count once
            if ((w.en || r.en) && model_drops != '1) begin
                model_drops++;
            end
        end else begin
            // The read sees the entry as it was before this cycle's write
            if (r.en) begin
                exp_rdata = model_entry(r.addr);
            end
            if (w.en && int'(w.addr) < DEPTH) begin
                mem_model[w.addr] = w.data;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
        check_data("rdata", rdata, exp_rdata);
        wr = '0;
        rd = '0;
    endtask

    task automatic test_done(input int num, input string name);
        $display("test %0d %s: %s", num, name, (fail_count == fails_before) ? "ok" : "errors");
        fails_before = fail_count;
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        rf_data_t          got;
        rf_data_t          data;
        logic [APB_AW-1:0] off;
        logic [APB_DW-1:0] stray_data;
        void'($urandom(SEED));
        apb_req       = '0;
        wr            = '0;
        rd            = '0;
        pass_count    = 0;
        fail_count    = 0;
        fails_before  = 0;
        exp_rdata     = '0;
        model_powered = 1'b0;
        model_drops   = '0;
        model_wake    = WAKE_W'(RESET_WAKE);
        for (int i = 0; i < DEPTH; i++) begin
            mem_model[i] = '0;
        end
        @(negedge reset);
        @(posedge clk);
        #(DRIVE_DLY);

        // Reset state
        check_bit("pwr_enable_b", pwr_enable_b, 1'b1);
        check_data("rdata", rdata, '0);
        read_and_compare("STATUS", REG_STATUS, STATUS_OFF, 1'b0);
        read_and_compare("CTRL", REG_CTRL, 32'h0, 1'b0);
        read_and_compare("DROP", REG_DROP, 32'h0, 1'b0);
        read_and_compare("WAKE", REG_WAKE, 32'(RESET_WAKE), 1'b0);
        test_done(1, "reset state");

        power_up(WAKE_W'(RESET_WAKE));
        power_down();
        test_done(2, "power sequence");

        power_up(WAKE_W'($urandom));
        repeat (TRAFFIC_CYCLES) random_cycle();
        idle_cycle();
        test_done(3, "random traffic");

        // Isolated array holds rdata at zero while every request is counted
        power_down();
        repeat (DROP_CYCLES) random_cycle();
        idle_cycle();
        read_and_compare("DROP", REG_DROP, 32'(model_drops), 1'b0);
        write_and_compare("DROP write pslverr", REG_DROP, $urandom, 1'b0);
        model_drops = '0;
        read_and_compare("DROP", REG_DROP, 32'h0, 1'b0);
        test_done(4, "dropped accesses");

        power_up(WAKE_W'($urandom));
        for (int a = 0; a < DEPTH; a++) begin
            data = rf_data_t'($urandom) | rf_data_t'(1);
            array_write(rf_addr_t'(a), data);
            mem_model[a] = data;
        end
        for (int a = 0; a < DEPTH; a++) begin
            array_read(rf_addr_t'(a), got);
            check_data("rdata", got, model_entry(rf_addr_t'(a)));
        end
        power_down();
        power_up(WAKE_W'($urandom));
        for (int a = 0; a < DEPTH; a++) begin
            array_read(rf_addr_t'(a), got);
            check_data("rdata after power cycle", got, '0);
        end
        test_done(5, "content loss");

        read_and_compare("unmapped 0x02", 8'h02, 32'h0, 1'b1);
        read_and_compare("unmapped 0xFC", 8'hFC, 32'h0, 1'b1);
        // Power request bit clear and wake field inverted, so a write that
        // leaked into CTRL or WAKE would show in the reads that follow
        stray_data = {{(APB_DW - WAKE_W){1'b1}}, ~model_wake[WAKE_W-1:1], 1'b0};
        repeat (4) begin
            do begin
                off = APB_AW'($urandom);
            end while (off inside {REG_CTRL, REG_WAKE, REG_STATUS, REG_DROP});
            read_and_compare("unmapped read", off, 32'h0, 1'b1);
            write_and_compare("unmapped write pslverr", off, stray_data, 1'b1);
        end
        // Nothing mapped moved after the unmapped writes
        read_and_compare("CTRL", REG_CTRL, 32'h1, 1'b0);
        read_and_compare("WAKE", REG_WAKE, 32'(model_wake), 1'b0);
        write_and_compare("STATUS write pslverr", REG_STATUS, 32'h7, 1'b0);
        read_and_compare("STATUS", REG_STATUS, STATUS_ON, 1'b0);
        check_bit("pwr_enable_b", pwr_enable_b, 1'b0);
        test_done(6, "APB errors");

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/rf_pkg.sv
logic/rf_array.sv
logic/rf_power_seq.sv
logic/rf_apb_regs.sv
logic/rf_mem_top.sv
tests/tb_clock_gen.sv
tests/rf_tb.sv

// File: Makefile
# Verilator build and run for the register file testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rf_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and the verdict comes from the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
